// File: design/coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module coreSequencer
    import rvSerialPkg::*;
(
    input  logic            cpuSignals,
    input  logic            rstN,
    input  memRsp_s         memRsp,
    input  decodedInsn_s    decoded,
    input  logic [xLen-1:0] xReg,
    input  logic            byteDone,
    input  logic            wordDone,
    output memReq_s         memReq,
    output shiftCtrl_s      shiftCtrl,
    output logic            fetchByteEn,
    output logic            presetWord
);

    typedef enum logic [1:0] {
        stFetch,
        stDispatch,
        stRead,
        stWrite
    } seqState_e;

    seqState_e            state;
    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] memAddr;
    logic                 memStrobe;
    logic                 memWe;
    // Pass mode selects rs2 into Y or rs1 through the ALU
    logic                 yFromXR;
    logic                 xFromAluR;
    // Kicks off eight shifts after a byte transfer
    logic                 shiftStart;
    logic                 isDispatch;
    logic                 passIdle;
    logic                 passDone;
    logic                 rdIsZero;

    // Byte address of a register in RAM
    function automatic logic [addrWidth-1:0] regAddr(input logic [regIdxWidth-1:0] idx);
        return regFileBase + addrWidth'(idx) * addrWidth'(regBytes);
    endfunction

    assign isDispatch = state == stDispatch;
    // No transfer or shift pending and the counter at a byte boundary
    assign passIdle = !memStrobe && !shiftStart && byteDone;
    assign passDone = (state == stRead) && passIdle && wordDone;
    assign rdIsZero = decoded.rdIdx == '0;

    always_comb begin
        shiftCtrl.xFromAlu = xFromAluR;
        shiftCtrl.yFromX = yFromXR;
        // Shift until the next byte boundary
        shiftCtrl.shiftEn = shiftStart
            || (((state == stRead) || (state == stWrite)) && !byteDone);
        shiftCtrl.loadByte = (state == stRead) && memStrobe && memRsp.ready;
        shiftCtrl.loadImmX = isDispatch && decoded.isLui;
        shiftCtrl.loadImmY = isDispatch && decoded.isAluOp && decoded.isAluImm;
        // Both operand passes start with a clean carry
        shiftCtrl.clearCarry = (isDispatch && decoded.isAluOp) || (passDone && yFromXR);
        presetWord = !rdIsZero
            && ((isDispatch && decoded.isLui) || (passDone && !yFromXR));
    end

    assign fetchByteEn = (state == stFetch) && memStrobe && memRsp.ready;

    assign memReq.address = memAddr;
    assign memReq.dataWrite = xReg[byteWidth-1:0];
    assign memReq.writeEnable = memWe;
    assign memReq.strobe = memStrobe;

    always_ff @(posedge cpuSignals) begin
        if (!rstN) begin
            state <= stFetch;
            pc <= resetPc;
            memAddr <= resetPc;
            memStrobe <= 1'b0;
            memWe <= 1'b0;
            yFromXR <= 1'b0;
            xFromAluR <= 1'b0;
            shiftStart <= 1'b0;
        end else begin
            if (shiftCtrl.shiftEn) begin
                shiftStart <= 1'b0;
            end
            case (state)
                stFetch: begin
                    if (memStrobe && memRsp.ready) begin
                        memStrobe <= 1'b0;
                        pc <= pc + 1'b1;
                        // Fourth byte in
                        if (pc[1:0] == 2'b11) begin
                            state <= stDispatch;
                        end
                    end else if (!memStrobe && !memRsp.ready) begin
                        memAddr <= pc;
                        memStrobe <= 1'b1;
                    end
                end
                stDispatch: begin
                    if (decoded.isLui && !rdIsZero) begin
                        memAddr <= regAddr(decoded.rdIdx);
                        memWe <= 1'b1;
                        state <= stWrite;
                    end else if (decoded.isAluOp) begin
                        // Immediate is already in Y, so go straight to rs1
                        xFromAluR <= decoded.isAluImm;
                        yFromXR <= !decoded.isAluImm;
                        memAddr <= regAddr(decoded.isAluImm ? decoded.rs1Idx : decoded.rs2Idx);
                        state <= stRead;
                    end else begin
                        // Unsupported or LUI to x0
                        state <= stFetch;
                    end
                end
                stRead: begin
                    if (memStrobe && memRsp.ready) begin
                        memStrobe <= 1'b0;
                        memAddr <= memAddr + 1'b1;
                        shiftStart <= 1'b1;
                    end else if (passDone) begin
                        if (yFromXR) begin
                            // With rs2 in Y bring rs1 through the ALU
                            yFromXR <= 1'b0;
                            xFromAluR <= 1'b1;
                            memAddr <= regAddr(decoded.rs1Idx);
                        end else begin
                            xFromAluR <= 1'b0;
                            if (rdIsZero) begin
                                state <= stFetch;
                            end else begin
                                memAddr <= regAddr(decoded.rdIdx);
                                memWe <= 1'b1;
                                state <= stWrite;
                            end
                        end
                    end else if (passIdle && !wordDone && !memRsp.ready) begin
                        memStrobe <= 1'b1;
                    end
                end
                stWrite: begin
                    if (memStrobe && memRsp.ready) begin
                        memStrobe <= 1'b0;
                        memAddr <= memAddr + 1'b1;
                        // Counter wrapped before the last byte went out
                        if (wordDone) begin
                            memWe <= 1'b0;
                            state <= stFetch;
                        end else begin
                            shiftStart <= 1'b1;
                        end
                    end else if (passIdle && !memRsp.ready) begin
                        memStrobe <= 1'b1;
                    end
                end
                default: begin
                    state <= stFetch;
                end
            endcase
        end
    end

    // Request is frozen until memory answers
    assert property (@(posedge cpuSignals) disable iff (!rstN)
        memReq.strobe && !memRsp.ready |=> $stable(memReq));

    // Instruction fetch is read only
    assert property (@(posedge cpuSignals) disable iff (!rstN)
        (state == stFetch) && memReq.strobe |-> !memReq.writeEnable);

endmodule

`default_nettype wire

// File: design/insnDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module insnDecoder
    import rvSerialPkg::*;
(
    input  insnWord_u    insn,
    output decodedInsn_s decoded
);

    logic       isFull;
    logic [4:0] majorOp;
    logic       isOpImm;
    logic       isOpReg;
    // funct7 must be zero or the SUB pattern
    logic       regFunctOk;
    logic [3:0] rawOp;

    always_comb begin
        // Low opcode bits are 11 for every 32-bit instruction
        isFull = insn.iView.opcode[1:0] == 2'b11;
        majorOp = insn.iView.opcode[6:2];
        isOpImm = isFull && (majorOp == opOpImm);
        isOpReg = isFull && (majorOp == opOp);
        regFunctOk = (insn.iView.imm[11] == 1'b0) && (insn.iView.imm[9:5] == 5'b00000);

        // Bit 30 belongs to the immediate in OP-IMM so it is dropped there
        rawOp = {isOpReg && insn.iView.imm[10], insn.iView.funct3};

        decoded.isLui = isFull && (majorOp == opLui);
        decoded.isAluImm = isOpImm;
        // Shifts and compares are not supported and fall through as no-ops
        decoded.isAluOp = (isOpImm || (isOpReg && regFunctOk))
            && (rawOp inside {aluAdd, aluSub, aluXor, aluOr, aluAnd});
        decoded.aluOp = aluOp_e'(rawOp);

        // Only sixteen registers, the index MSB is ignored
        decoded.rs1Idx = insn.iView.rs1[regIdxWidth-1:0];
        decoded.rs2Idx = insn.iView.imm[regIdxWidth-1:0];
        decoded.rdIdx = insn.iView.rd[regIdxWidth-1:0];

        if (decoded.isLui) begin
            // Upper 20 bits, low 12 zero
            decoded.immediate = {insn.uView.upperImm, 12'b0};
        end else begin
            // Sign-extended 12-bit immediate
            decoded.immediate = {{20{insn.iView.imm[11]}}, insn.iView.imm};
        end
    end

endmodule

`default_nettype wire

// File: design/insnFetchBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module insnFetchBuffer
    import rvSerialPkg::*;
(
    input  logic                 cpuSignals,
    input  logic                 rstN,
    input  logic                 fetchByteEn,
    input  logic [byteWidth-1:0] dataRead,
    output insnWord_u            insn
);

    // Raw instruction bits while they arrive
    logic [xLen-1:0] buffer;

    // Bytes enter at the top and move down
    // After four reads the first byte sits in bits 7:0
    always_ff @(posedge cpuSignals) begin
        if (!rstN) begin
            // All zero decodes as a no-op
            buffer <= '0;
        end else if (fetchByteEn) begin
            buffer <= {dataRead, buffer[xLen-1:byteWidth]};
        end
    end

    // Decoder picks its own view of the same word
    assign insn = buffer;

endmodule

`default_nettype wire

// File: design/rvSerialCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvSerialCore
    import rvSerialPkg::*;
(
    input  logic    cpuSignals,
    input  logic    rstN,
    output memReq_s memReq,
    input  memRsp_s memRsp
);

    insnWord_u       insn;
    decodedInsn_s    decoded;
    shiftCtrl_s      shiftCtrl;
    logic [xLen-1:0] xReg;
    logic            byteDone;
    logic            wordDone;
    logic            fetchByteEn;
    logic            presetWord;

    // Steps every instruction and owns the bus
    coreSequencer sequencer0 (
        .cpuSignals (cpuSignals),
        .rstN       (rstN),
        .memRsp     (memRsp),
        .decoded    (decoded),
        .xReg       (xReg),
        .byteDone   (byteDone),
        .wordDone   (wordDone),
        .memReq     (memReq),
        .shiftCtrl  (shiftCtrl),
        .fetchByteEn(fetchByteEn),
        .presetWord (presetWord)
    );

    insnFetchBuffer fetchBuffer0 (
        .cpuSignals (cpuSignals),
        .rstN       (rstN),
        .fetchByteEn(fetchByteEn),
        .dataRead   (memRsp.dataRead),
        .insn       (insn)
    );

    insnDecoder decoder0 (
        .insn   (insn),
        .decoded(decoded)
    );

    // X and Y with the one-bit ALU
    serialDatapath datapath0 (
        .cpuSignals(cpuSignals),
        .shiftCtrl (shiftCtrl),
        .aluOp     (decoded.aluOp),
        .immediate (decoded.immediate),
        .dataRead  (memRsp.dataRead),
        .xReg      (xReg)
    );

    shiftCounter counter0 (
        .cpuSignals(cpuSignals),
        .rstN      (rstN),
        .shiftCtrl (shiftCtrl),
        .presetWord(presetWord),
        .byteDone  (byteDone),
        .wordDone  (wordDone)
    );

endmodule

`default_nettype wire

// File: design/rvSerialPkg.sv
`default_nettype none

package rvSerialPkg;

    // Bus and register widths
    localparam int addrWidth = 16;
    localparam int xLen = 32;
    localparam int byteWidth = 8;
    localparam int regIdxWidth = 4;
    // Each register takes four bytes of RAM
    localparam int regBytes = 4;

    // Execution starts here after reset
    localparam logic [addrWidth-1:0] resetPc = 16'h2000;
    // x0 sits at this byte address, x15 ends at 63
    localparam logic [addrWidth-1:0] regFileBase = '0;

    // Major opcodes, instruction bits 6:2
    localparam logic [4:0] opLui = 5'b01101;
    localparam logic [4:0] opOpImm = 5'b00100;
    localparam logic [4:0] opOp = 5'b01100;

    // Write-back starts at one byte in, so only 24 shifts follow
    localparam logic [4:0] wordPreset = 5'd8;

    // Encoding is {bit 30, funct3} straight from the instruction
    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSub = 4'b1000,
        aluXor = 4'b0100,
        aluOr  = 4'b0110,
        aluAnd = 4'b0111
    } aluOp_e;

    // I-format fields, also the source of rs2 and bit 30
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat_s;

    // U-format fields for LUI
    typedef struct packed {
        logic [19:0] upperImm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFormat_s;

    typedef union packed {
        iFormat_s iView;
        uFormat_s uView;
    } insnWord_u;

    typedef struct packed {
        logic                   isLui;
        logic                   isAluOp;
        // Operand two is the immediate instead of rs2
        logic                   isAluImm;
        aluOp_e                 aluOp;
        logic [regIdxWidth-1:0] rs1Idx;
        logic [regIdxWidth-1:0] rs2Idx;
        logic [regIdxWidth-1:0] rdIdx;
        logic [xLen-1:0]        immediate;
    } decodedInsn_s;

    // Core to memory
    typedef struct packed {
        logic [addrWidth-1:0] address;
        logic [byteWidth-1:0] dataWrite;
        logic                 writeEnable;
        logic                 strobe;
    } memReq_s;

    // Memory to core
    typedef struct packed {
        logic [byteWidth-1:0] dataRead;
        logic                 ready;
    } memRsp_s;

    // Sequencer commands for the shifter and its counter
    typedef struct packed {
        logic shiftEn;
        // X top bit comes from the ALU, otherwise X rotates
        logic xFromAlu;
        // Y top bit comes from X bit 0, otherwise Y rotates
        logic yFromX;
        logic loadByte;
        logic loadImmX;
        logic loadImmY;
        // Also restarts the shift counter for a new pass
        logic clearCarry;
    } shiftCtrl_s;

endpackage

`default_nettype wire

// File: design/serialDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module serialDatapath
    import rvSerialPkg::*;
(
    input  logic                 cpuSignals,
    input  shiftCtrl_s           shiftCtrl,
    input  aluOp_e               aluOp,
    input  logic [xLen-1:0]      immediate,
    input  logic [byteWidth-1:0] dataRead,
    output logic [xLen-1:0]      xReg
);

    // The only two working registers of the core
    logic [xLen-1:0] xQ;
    logic [xLen-1:0] yQ;
    // Add carry or subtract borrow between bits
    logic            carry;
    logic            aluBit;
    logic            aluCarry;

    // One-bit ALU on the two LSBs, LSB first
    always_comb begin
        case (aluOp)
            aluAdd: begin
                {aluCarry, aluBit} = 2'(xQ[0]) + 2'(yQ[0]) + 2'(carry);
            end
            aluSub: begin
                // Borrow shows up as bit 1 of the two-bit difference
                {aluCarry, aluBit} = 2'(xQ[0]) - 2'(yQ[0]) - 2'(carry);
            end
            aluXor: begin
                aluBit = xQ[0] ^ yQ[0];
                aluCarry = 1'b0;
            end
            aluOr: begin
                aluBit = xQ[0] | yQ[0];
                aluCarry = 1'b0;
            end
            aluAnd: begin
                aluBit = xQ[0] & yQ[0];
                aluCarry = 1'b0;
            end
            default: begin
                aluBit = 1'b0;
                aluCarry = 1'b0;
            end
        endcase
    end

    always_ff @(posedge cpuSignals) begin
        // X gets an immediate, a memory byte or a shift
        if (shiftCtrl.loadImmX) begin
            xQ <= immediate;
        end else if (shiftCtrl.loadByte) begin
            xQ[byteWidth-1:0] <= dataRead;
        end else if (shiftCtrl.shiftEn) begin
            xQ <= {shiftCtrl.xFromAlu ? aluBit : xQ[0], xQ[xLen-1:1]};
        end

        // Y follows X when collecting rs2, else it rotates
        if (shiftCtrl.loadImmY) begin
            yQ <= immediate;
        end else if (shiftCtrl.shiftEn) begin
            yQ <= {shiftCtrl.yFromX ? xQ[0] : yQ[0], yQ[xLen-1:1]};
        end

        if (shiftCtrl.clearCarry) begin
            carry <= 1'b0;
        end else if (shiftCtrl.shiftEn && shiftCtrl.xFromAlu) begin
            carry <= aluCarry;
        end
    end

    assign xReg = xQ;

endmodule

`default_nettype wire

// File: design/shiftCounter.sv
`timescale 1ns/1ps
`default_nettype none

module shiftCounter
    import rvSerialPkg::*;
(
    input  logic       cpuSignals,
    input  logic       rstN,
    input  shiftCtrl_s shiftCtrl,
    input  logic       presetWord,
    output logic       byteDone,
    output logic       wordDone
);

    // Bits shifted in the current pass
    logic [4:0] count;
    // Set once the count wraps past 31
    logic       wrapped;

    always_ff @(posedge cpuSignals) begin
        if (!rstN) begin
            count <= '0;
            wrapped <= 1'b0;
        end else if (presetWord) begin
            // Write-back pass skips the shifts for the first byte
            count <= wordPreset;
            wrapped <= 1'b0;
        end else if (shiftCtrl.clearCarry) begin
            // Operand pass starts from zero
            count <= '0;
            wrapped <= 1'b0;
        end else if (shiftCtrl.shiftEn) begin
            count <= count + 5'd1;
            if (count == 5'd31) begin
                wrapped <= 1'b1;
            end
        end
    end

    // Eight shifts done since the last boundary
    assign byteDone = count[2:0] == 3'b000;
    assign wordDone = wrapped;

    // Every commanded shift moves the count by one
    assert property (@(posedge cpuSignals) disable iff (!rstN)
        shiftCtrl.shiftEn |=> count == $past(count) + 5'd1);

endmodule

`default_nettype wire

// File: list.f
design/rvSerialPkg.sv
design/insnDecoder.sv
design/insnFetchBuffer.sv
design/shiftCounter.sv
design/serialDatapath.sv
design/coreSequencer.sv
design/rvSerialCore.sv
tb/ramModel.sv
tb/rvSerialCoreTb.sv

// File: tb/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

module ramModel
    import rvSerialPkg::*;
#(
    parameter logic [31:0] seedInit = 32'h1
)
(
    input  logic    cpuSignals,
    input  memReq_s memReq,
    output memRsp_s memRsp
);

    // Whole 64 KiB address space, loaded by the testbench
    logic [byteWidth-1:0] mem [0:(1 << addrWidth) - 1];

    int   seed;
    // A request is counting down its latency
    logic busy;
    int   delayLeft;

    // Response changes 1 ns after the rising edge
    initial begin
        seed = seedInit;
        busy = 1'b0;
        delayLeft = 0;
        memRsp = '0;
        forever begin
            @(posedge cpuSignals);
            #1;
            if (memRsp.ready) begin
                // Hold ready until the core lets go of strobe
                if (!memReq.strobe) begin
                    memRsp.ready = 1'b0;
                end
            end else if (memReq.strobe) begin
                if (!busy) begin
                    busy = 1'b1;
                    // Zero extra wait means ready one cycle after strobe
                    delayLeft = $unsigned($random(seed)) % 3;
                end
                if (delayLeft == 0) begin
                    busy = 1'b0;
                    if (memReq.writeEnable) begin
                        mem[memReq.address] = memReq.dataWrite;
                    end else begin
                        memRsp.dataRead = mem[memReq.address];
                    end
                    memRsp.ready = 1'b1;
                end else begin
                    delayLeft = delayLeft - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/rvSerialCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvSerialCoreTb
    import rvSerialPkg::*;
();

    localparam logic [31:0] seedValue = 32'h8245e214;
    localparam int numInsns = 60;
    localparam int resetCycles = 16;
    localparam int driveDelay = 1;
    localparam int firstFetchLimit = 20;
    localparam int runLimit = 40000;
    // Fetch at this address means the last instruction has retired
    localparam logic [addrWidth-1:0] progEnd = resetPc + addrWidth'(4 * numInsns);
    localparam logic [addrWidth-1:0] regFileEnd = regFileBase + addrWidth'(16 * regBytes);

    logic                 cpuSignals = 1'b0;
    logic                 rstN;
    memReq_s              memReq;
    memRsp_s              memRsp;
    int                   seed;
    // Expected register file
    logic [xLen-1:0]      modelRegs [0:15];
    logic [addrWidth-1:0] expectedFetch;
    logic                 programDone;
    // Bus as seen at the previous falling edge
    logic                 prevStrobe;
    logic                 prevReady;
    memReq_s              prevReq;

    always #50 cpuSignals = ~cpuSignals;

    rvSerialCore dut0 (
        .cpuSignals(cpuSignals),
        .rstN      (rstN),
        .memReq    (memReq),
        .memRsp    (memRsp)
    );

    ramModel #(.seedInit(seedValue)) ram0 (
        .cpuSignals(cpuSignals),
        .memReq    (memReq),
        .memRsp    (memRsp)
    );

    task automatic compareValues(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reportHang(input string where);
        $display("Timeout at %0t ns: %s", $time, where);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped by a timeout");
    endtask

    // Little-endian word into RAM
    task automatic storeWord(input logic [addrWidth-1:0] addr, input logic [31:0] word);
        for (int b = 0; b < 4; b++) begin
            ram0.mem[addr + addrWidth'(b)] = word[8*b +: 8];
        end
    endtask

    function automatic logic [31:0] readWord(input logic [addrWidth-1:0] addr);
        return {ram0.mem[addr + 16'd3], ram0.mem[addr + 16'd2],
                ram0.mem[addr + 16'd1], ram0.mem[addr]};
    endfunction

    // Reference result from funct3 where SUB needs funct3 000
    function automatic logic [31:0] modelAlu(input logic [2:0] funct3, input logic isSub,
                                             input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'b000: return isSub ? a - b : a + b;
            3'b100: return a ^ b;
            3'b110: return a | b;
            3'b111: return a & b;
            default: return 32'h0;
        endcase
    endfunction

    task automatic loadRegisters();
        for (int r = 0; r < 16; r++) begin
            modelRegs[r] = (r == 0) ? 32'h0 : $random(seed);
            storeWord(regFileBase + addrWidth'(r * regBytes), modelRegs[r]);
        end
    endtask

    // Random LUI, OP-IMM and OP instructions run on the model as they are made
    task automatic buildProgram();
        logic [31:0] insn;
        logic [31:0] result;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [2:0]  funct3;
        logic        isSub;
        logic [11:0] imm12;
        logic [19:0] upper;
        int          kind;
        int          pick;
        for (int i = 0; i < numInsns; i++) begin
            kind = $unsigned($random(seed)) % 3;
            rd = 4'($random(seed));
            rs1 = 4'($random(seed));
            rs2 = 4'($random(seed));
            pick = $unsigned($random(seed)) % 5;
            // ADD, XOR, OR, AND and SUB in that order
            funct3 = (pick == 1) ? 3'b100 : (pick == 2) ? 3'b110 : (pick == 3) ? 3'b111 : 3'b000;
            isSub = pick == 4;
            case (kind)
                0: begin
                    upper = 20'($random(seed));
                    insn = {upper, 1'b0, rd, 7'b0110111};
                    result = {upper, 12'h000};
                end
                1: begin
                    // No SUB in the immediate form
                    imm12 = 12'($random(seed));
                    insn = {imm12, 1'b0, rs1, funct3, 1'b0, rd, 7'b0010011};
                    result = modelAlu(funct3, 1'b0, modelRegs[rs1], {{20{imm12[11]}}, imm12});
                end
                default: begin
                    insn = {1'b0, isSub, 5'b00000, 1'b0, rs2, 1'b0, rs1, funct3, 1'b0, rd,
                            7'b0110011};
                    result = modelAlu(funct3, isSub, modelRegs[rs1], modelRegs[rs2]);
                end
            endcase
            // x0 is hardwired
            if (rd != 4'd0) begin
                modelRegs[rd] = result;
            end
            storeWord(resetPc + addrWidth'(4 * i), insn);
        end
    endtask

    task automatic checkRegisters();
        logic [31:0] word;
        for (int r = 0; r < 16; r++) begin
            word = readWord(regFileBase + addrWidth'(r * regBytes));
            compareValues(word, modelRegs[r], $sformatf("register x%0d in RAM", r));
        end
    endtask

    // Bus watcher samples between the drive edges
    always @(negedge cpuSignals) begin
        if (rstN) begin
            if (prevStrobe && !prevReady) begin
                compareValues(32'(memReq), 32'(prevReq), "request held while ready is low");
            end
            // Start of a new transfer
            if (memReq.strobe && !prevStrobe) begin
                if (memReq.writeEnable) begin
                    compareValues(32'(memReq.address >= regFileBase + addrWidth'(regBytes)
                                      && memReq.address < regFileEnd), 32'd1,
                                  "write address inside x1 to x15");
                end else if (memReq.address >= resetPc) begin
                    compareValues(32'(memReq.address), 32'(expectedFetch), "fetch address");
                    if (memReq.address == progEnd) begin
                        programDone = 1'b1;
                    end
                    expectedFetch = expectedFetch + 1'b1;
                end else begin
                    compareValues(32'(memReq.address < regFileEnd), 32'd1,
                                  "operand read inside the register file");
                end
            end
        end
        prevStrobe = memReq.strobe;
        prevReady = memRsp.ready;
        prevReq = memReq;
    end

    initial begin
        int waitCycles;
        seed = seedValue;
        rstN = 1'b0;
        programDone = 1'b0;
        expectedFetch = resetPc;
        prevStrobe = 1'b0;
        prevReady = 1'b0;
        prevReq = '0;
        // Background pattern that differs with every address bit
        for (int a = 0; a < (1 << addrWidth); a++) begin
            ram0.mem[a] = 8'(a) ^ 8'(a >> 8);
        end
        loadRegisters();
        buildProgram();

        repeat (resetCycles) @(posedge cpuSignals);
        #driveDelay;
        rstN = 1'b1;

        // Idle bus straight out of reset
        @(negedge cpuSignals);
        compareValues(32'(memReq.strobe), 32'd0, "strobe after reset");
        compareValues(32'(memReq.writeEnable), 32'd0, "writeEnable after reset");
        compareValues(32'(memReq.address), 32'(resetPc), "address after reset");

        waitCycles = 0;
        while (!memReq.strobe) begin
            @(negedge cpuSignals);
            waitCycles = waitCycles + 1;
            if (waitCycles > firstFetchLimit) begin
                reportHang("the core never started its first fetch");
            end
        end
        compareValues(32'(memReq.address), 32'(resetPc), "first fetch address");

        // Run until the fetch after the last instruction
        waitCycles = 0;
        while (!programDone) begin
            @(posedge cpuSignals);
            waitCycles = waitCycles + 1;
            if (waitCycles > runLimit) begin
                reportHang("the program never reached its last instruction");
            end
        end

        checkRegisters();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
